//--- hw/trans_fmt_pkg.sv
package trans_fmt_pkg;

    // ========================================================================
    // Q15.16 signed fixed-point word
    // ========================================================================

    localparam int FRAC_W = 16;
    localparam int WORD_W = 32;

    typedef logic signed [WORD_W-1:0] word_t;

    // pi/2 scaled by 2^16
    localparam word_t HALF_PI = 32'sd102944;

    // ========================================================================
    // CORDIC constants
    // ========================================================================

    localparam int CORDIC_ITERS = 16;

    // 1/K for 16 micro-rotations, loaded as the starting x in rotation mode
    localparam word_t CORDIC_GAIN_INV = 32'sd39797;

    // Entry i is atan(2^-i) scaled by 2^16, rounded to nearest
    localparam word_t ATAN_TABLE [CORDIC_ITERS] = '{
        32'sd51472, 32'sd30386, 32'sd16055, 32'sd8150,
        32'sd4091,  32'sd2047,  32'sd1024,  32'sd512,
        32'sd256,   32'sd128,   32'sd64,    32'sd32,
        32'sd16,    32'sd8,     32'sd4,     32'sd2
    };

    // ========================================================================
    // Square root
    // ========================================================================

    // Radicand is 48 bits after the Q15.16 shift, so the root has 24 bits
    localparam int SQRT_STEPS = 24;

endpackage

//--- hw/trans_op_pkg.sv
package trans_op_pkg;

    import trans_fmt_pkg::*;

    // ========================================================================
    // Operation codes
    // ========================================================================

    // Codes 4 and 6..15 are not decoded and come back as errors
    typedef enum logic [3:0] {
        OP_SQRT   = 4'd0,
        OP_SIN    = 4'd1,
        OP_COS    = 4'd2,
        OP_SINCOS = 4'd3,
        OP_ATAN   = 4'd5
    } trans_op_e;

    // ========================================================================
    // Channel payloads
    // ========================================================================

    // Request word
    // operand_b is only read by ATAN (the y coordinate)
    typedef struct packed {
        trans_op_e op;
        word_t     operand_a;
        word_t     operand_b;
    } trans_req_t;

    // Response word
    // secondary carries cos for SINCOS, otherwise zero
    typedef struct packed {
        word_t primary;
        word_t secondary;
        logic  has_secondary;
        logic  error;
    } trans_rsp_t;

endpackage

//--- hw/trans_skid_buffer.sv
`timescale 1ns/1ps

module trans_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Main slot drives the output, skid slot catches data while stalled
    payload_t main_q;
    payload_t skid_q;
    logic     main_valid;
    logic     skid_valid;
    logic     in_fire;
    logic     main_free;

    // Ready comes straight from a flop, no path from out_ready
    assign in_ready  = ~skid_valid;
    assign out_valid = main_valid;
    assign out_data  = main_q;

    assign in_fire = in_valid & in_ready;

    // Main slot empties this cycle, or is already empty
    assign main_free = ~main_valid | out_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // Skid entry is older, it moves up first
            if (skid_valid) begin
                main_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                main_valid <= in_fire;
            end
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            main_q <= skid_valid ? skid_q : in_data;
        end else if (in_fire) begin
            skid_q <= in_data;
        end
    end

endmodule

//--- hw/cordic_engine.sv
`timescale 1ns/1ps

module cordic_engine
    import trans_fmt_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  logic  vectoring,
    input  word_t x_in,
    input  word_t y_in,
    input  word_t z_in,
    output logic  done,
    output word_t x_out,
    output word_t y_out,
    output word_t z_out
);

    // ========================================================================
    // Control
    // ========================================================================

    logic                            busy_q;
    logic                            vect_q;
    logic [$clog2(CORDIC_ITERS)-1:0] iter_q;
    logic                            last_iter;

    assign last_iter = (iter_q == CORDIC_ITERS - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            vect_q <= 1'b0;
            iter_q <= '0;
            done   <= 1'b0;
        end else begin
            // Done is a single-cycle pulse
            done <= 1'b0;
            if (start && !busy_q) begin
                busy_q <= 1'b1;
                vect_q <= vectoring;
                iter_q <= '0;
            end else if (busy_q) begin
                iter_q <= iter_q + 1'b1;
                if (last_iter) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Micro-rotation datapath
    // ========================================================================

    word_t x_q;
    word_t y_q;
    word_t z_q;
    word_t x_sh;
    word_t y_sh;
    logic  dir_pos;

    // Arithmetic shifts keep the sign of x and y
    assign x_sh = x_q >>> iter_q;
    assign y_sh = y_q >>> iter_q;

    // Rotation drives z toward zero, vectoring drives y toward zero
    assign dir_pos = vect_q ? y_q[WORD_W-1] : ~z_q[WORD_W-1];

    always_ff @(posedge clk) begin
        if (start && !busy_q) begin
            x_q <= x_in;
            y_q <= y_in;
            z_q <= z_in;
        end else if (busy_q) begin
            if (dir_pos) begin
                x_q <= x_q - y_sh;
                y_q <= y_q + x_sh;
                z_q <= z_q - ATAN_TABLE[iter_q];
            end else begin
                x_q <= x_q + y_sh;
                y_q <= y_q - x_sh;
                z_q <= z_q + ATAN_TABLE[iter_q];
            end
        end
    end

    // Results stay valid from done until the next start
    assign x_out = x_q;
    assign y_out = y_q;
    assign z_out = z_q;

endmodule

//--- hw/sqrt_engine.sv
`timescale 1ns/1ps

module sqrt_engine
    import trans_fmt_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  word_t radicand,
    output logic  done,
    output word_t root
);

    // Control
    logic                          busy_q;
    logic [$clog2(SQRT_STEPS)-1:0] step_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            step_q <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy_q) begin
                busy_q <= 1'b1;
                step_q <= '0;
            end else if (busy_q) begin
                step_q <= step_q + 1'b1;
                if (step_q == SQRT_STEPS - 1) begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Restoring square root, one root bit per cycle
    // ========================================================================

    logic [WORD_W+FRAC_W-1:0] opnd_q;
    logic [SQRT_STEPS:0]      rem_q;
    logic [SQRT_STEPS-1:0]    root_q;
    logic [SQRT_STEPS+2:0]    rem_sh;
    logic [SQRT_STEPS+2:0]    trial;
    logic                     fits;

    // Bring down the next two radicand bits
    assign rem_sh = {rem_q, opnd_q[WORD_W+FRAC_W-1 -: 2]};
    // Trial divisor is 4*root + 1
    assign trial  = {1'b0, root_q, 2'b01};
    assign fits   = (rem_sh >= trial);

    always_ff @(posedge clk) begin
        if (start && !busy_q) begin
            // Scale by 2^16 so the root comes out in Q15.16
            opnd_q <= {radicand, {FRAC_W{1'b0}}};
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy_q) begin
            opnd_q <= opnd_q << 2;
            // Remainder never exceeds 2*root, so the top bits drop safely
            rem_q  <= fits ? (SQRT_STEPS+1)'(rem_sh - trial) : (SQRT_STEPS+1)'(rem_sh);
            root_q <= {root_q[SQRT_STEPS-2:0], fits};
        end
    end

    // Root is non-negative, pad with zeros
    assign root = {{(WORD_W-SQRT_STEPS){1'b0}}, root_q};

endmodule

//--- hw/trans_dispatch.sv
`timescale 1ns/1ps

module trans_dispatch
    import trans_fmt_pkg::*;
    import trans_op_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    output logic       req_ready,
    input  trans_req_t req,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output trans_rsp_t rsp,
    output logic       cordic_start,
    output logic       cordic_vectoring,
    output word_t      cordic_x,
    output word_t      cordic_y,
    output word_t      cordic_z,
    input  logic       cordic_done,
    input  word_t      cordic_x_res,
    input  word_t      cordic_y_res,
    input  word_t      cordic_z_res,
    output logic       sqrt_start,
    output word_t      sqrt_radicand,
    input  logic       sqrt_done,
    input  word_t      sqrt_root
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_CORDIC,
        S_WAIT_SQRT,
        S_RESPOND
    } state_e;

    state_e     state_q;
    trans_op_e  op_q;
    trans_rsp_t rsp_q;
    logic       accept;
    logic       req_err;

    assign req_ready = (state_q == S_IDLE);
    assign rsp_valid = (state_q == S_RESPOND);
    assign rsp       = rsp_q;
    assign accept    = req_valid & req_ready;

    // ========================================================================
    // Operand checks, engines only ever see legal requests
    // ========================================================================

    always_comb begin
        unique case (req.op)
            OP_SIN, OP_COS, OP_SINCOS: begin
                req_err = (req.operand_a > HALF_PI) || (req.operand_a < -HALF_PI);
            end
            // x must be strictly positive
            OP_ATAN: req_err = (req.operand_a <= 0);
            OP_SQRT: req_err = (req.operand_a < 0);
            default: req_err = 1'b1;
        endcase
    end

    // ========================================================================
    // Routing FSM
    // ========================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q          <= S_IDLE;
            op_q             <= OP_SQRT;
            cordic_start     <= 1'b0;
            cordic_vectoring <= 1'b0;
            sqrt_start       <= 1'b0;
        end else begin
            // Start strobes last one cycle
            cordic_start <= 1'b0;
            sqrt_start   <= 1'b0;
            unique case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        op_q <= req.op;
                        if (req_err) begin
                            state_q <= S_RESPOND;
                        end else if (req.op == OP_SQRT) begin
                            sqrt_start <= 1'b1;
                            state_q    <= S_WAIT_SQRT;
                        end else begin
                            cordic_start     <= 1'b1;
                            cordic_vectoring <= (req.op == OP_ATAN);
                            state_q          <= S_WAIT_CORDIC;
                        end
                    end
                end
                S_WAIT_CORDIC: if (cordic_done) state_q <= S_RESPOND;
                S_WAIT_SQRT:   if (sqrt_done) state_q <= S_RESPOND;
                // Hold until the output buffer takes the response
                S_RESPOND:     if (rsp_ready) state_q <= S_IDLE;
                default:       state_q <= S_IDLE;
            endcase
        end
    end

    // ========================================================================
    // Engine operands and response assembly
    // ========================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            // Rotation starts from (1/K, 0, angle), vectoring from (x, y, 0)
            if (req.op == OP_ATAN) begin
                cordic_x <= req.operand_a;
                cordic_y <= req.operand_b;
                cordic_z <= '0;
            end else begin
                cordic_x <= CORDIC_GAIN_INV;
                cordic_y <= '0;
                cordic_z <= req.operand_a;
            end
            sqrt_radicand <= req.operand_a;
            // Error response is ready in the next cycle
            rsp_q       <= '0;
            rsp_q.error <= req_err;
        end else if (state_q == S_WAIT_CORDIC && cordic_done) begin
            unique case (op_q)
                OP_COS:  rsp_q.primary <= cordic_x_res;
                OP_ATAN: rsp_q.primary <= cordic_z_res;
                OP_SINCOS: begin
                    rsp_q.primary       <= cordic_y_res;
                    rsp_q.secondary     <= cordic_x_res;
                    rsp_q.has_secondary <= 1'b1;
                end
                default: rsp_q.primary <= cordic_y_res;
            endcase
        end else if (state_q == S_WAIT_SQRT && sqrt_done) begin
            rsp_q.primary <= sqrt_root;
        end
    end

endmodule

//--- hw/fpu_trans_top.sv
`timescale 1ns/1ps

module fpu_trans_top
    import trans_fmt_pkg::*;
    import trans_op_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    output logic       req_ready,
    input  trans_req_t req,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output trans_rsp_t rsp
);

    // Buffered request and response channels
    logic       in_valid, in_ready, out_valid, out_ready;
    trans_req_t in_req;
    trans_rsp_t out_rsp;

    // Engine hookup
    logic  cordic_start, cordic_vectoring, cordic_done;
    word_t cordic_x, cordic_y, cordic_z;
    word_t cordic_x_res, cordic_y_res, cordic_z_res;
    logic  sqrt_start, sqrt_done;
    word_t sqrt_radicand, sqrt_root;

    trans_skid_buffer #(.payload_t(trans_req_t)) u_req_buf (
        .clk(clk), .reset(reset),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(in_valid), .out_ready(in_ready), .out_data(in_req)
    );

    trans_dispatch u_dispatch (
        .clk(clk), .reset(reset),
        .req_valid(in_valid), .req_ready(in_ready), .req(in_req),
        .rsp_valid(out_valid), .rsp_ready(out_ready), .rsp(out_rsp),
        .cordic_start(cordic_start), .cordic_vectoring(cordic_vectoring),
        .cordic_x(cordic_x), .cordic_y(cordic_y), .cordic_z(cordic_z),
        .cordic_done(cordic_done), .cordic_x_res(cordic_x_res),
        .cordic_y_res(cordic_y_res), .cordic_z_res(cordic_z_res),
        .sqrt_start(sqrt_start), .sqrt_radicand(sqrt_radicand),
        .sqrt_done(sqrt_done), .sqrt_root(sqrt_root)
    );

    cordic_engine u_cordic (
        .clk(clk), .reset(reset), .start(cordic_start), .vectoring(cordic_vectoring),
        .x_in(cordic_x), .y_in(cordic_y), .z_in(cordic_z), .done(cordic_done),
        .x_out(cordic_x_res), .y_out(cordic_y_res), .z_out(cordic_z_res)
    );

    sqrt_engine u_sqrt (
        .clk(clk), .reset(reset), .start(sqrt_start), .radicand(sqrt_radicand),
        .done(sqrt_done), .root(sqrt_root)
    );

    trans_skid_buffer #(.payload_t(trans_rsp_t)) u_rsp_buf (
        .clk(clk), .reset(reset),
        .in_valid(out_valid), .in_ready(out_ready), .in_data(out_rsp),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp)
    );

endmodule

//--- tb/tb_fpu_trans.sv
`timescale 1ns/1ps

module tb_fpu_trans
    import trans_fmt_pkg::*;
    import trans_op_pkg::*;
();

    // ========================================================================
    // Test sizing
    // ========================================================================

    localparam int N_TRIG_DIR  = 21;
    localparam int N_ERR_DIR   = 9;
    localparam int N_SQRT_DIR  = 3;
    localparam int N_TRIG_RAND = 20;
    localparam int N_ATAN_RAND = 15;
    localparam int N_SQRT_RAND = 15;
    localparam int N_MIXED     = 30;
    localparam int NUM_TESTS   = N_TRIG_DIR + N_ERR_DIR + N_SQRT_DIR + N_TRIG_RAND
                               + N_ATAN_RAND + N_SQRT_RAND + N_MIXED;
    // Generous per-request budget, back-pressure included
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 60 + 200;

    logic       clk;
    logic       reset;
    logic       req_valid;
    logic       req_ready;
    trans_req_t req;
    logic       rsp_valid;
    logic       rsp_ready;
    trans_rsp_t rsp;

    integer     seed;
    logic       stall_enable;
    int         stall_left;
    int         sent_count;
    int         rsp_count;
    int         cycle_count = 0;
    word_t      atan_tab [CORDIC_ITERS];
    trans_rsp_t exp_q [$];

    fpu_trans_top dut (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d of %0d responses seen",
                                TIMEOUT_CYCLES, rsp_count, sent_count));
        end
    end

    // ========================================================================
    // Reference model
    // ========================================================================

    // Plain shift-add CORDIC, direction from z (rotation) or y (vectoring)
    function automatic void cordic_ref(input logic vect, input word_t x0, input word_t y0,
                                       input word_t z0, output word_t xr, output word_t yr,
                                       output word_t zr);
        word_t x;
        word_t y;
        word_t z;
        word_t xs;
        word_t ys;
        logic  d_pos;
        x = x0;
        y = y0;
        z = z0;
        for (int i = 0; i < CORDIC_ITERS; i++) begin
            d_pos = vect ? (y < 0) : (z >= 0);
            xs = x >>> i;
            ys = y >>> i;
            if (d_pos) begin
                x = x - ys;
                y = y + xs;
                z = z - atan_tab[i];
            end else begin
                x = x + ys;
                y = y - xs;
                z = z + atan_tab[i];
            end
        end
        xr = x;
        yr = y;
        zr = z;
    endfunction

    // Floor of sqrt(a * 2^16), found by bisection over the root range
    function automatic word_t sqrt_ref(input word_t a);
        longint unsigned v;
        longint unsigned lo;
        longint unsigned hi;
        longint unsigned mid;
        v  = longint'(a) << FRAC_W;
        lo = 0;
        hi = 64'd1 << SQRT_STEPS;
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= v)
                lo = mid;
            else
                hi = mid;
        end
        return word_t'(lo);
    endfunction

    function automatic trans_rsp_t expected_rsp(input trans_req_t r);
        trans_rsp_t e;
        word_t      xr;
        word_t      yr;
        word_t      zr;
        e = '0;
        case (r.op)
            OP_SIN, OP_COS, OP_SINCOS: begin
                if (r.operand_a > HALF_PI || r.operand_a < -HALF_PI) begin
                    e.error = 1'b1;
                end else begin
                    cordic_ref(1'b0, CORDIC_GAIN_INV, '0, r.operand_a, xr, yr, zr);
                    e.primary = (r.op == OP_COS) ? xr : yr;
                    if (r.op == OP_SINCOS) begin
                        e.secondary     = xr;
                        e.has_secondary = 1'b1;
                    end
                end
            end
            OP_ATAN: begin
                if (r.operand_a <= 0) begin
                    e.error = 1'b1;
                end else begin
                    cordic_ref(1'b1, r.operand_a, r.operand_b, '0, xr, yr, zr);
                    e.primary = zr;
                end
            end
            OP_SQRT: begin
                if (r.operand_a < 0)
                    e.error = 1'b1;
                else
                    e.primary = sqrt_ref(r.operand_a);
            end
            // Anything not decoded
            default: e.error = 1'b1;
        endcase
        return e;
    endfunction

    // ========================================================================
    // Compare tasks and response checker
    // ========================================================================

    task automatic check_word(input string field, input word_t got, input word_t want);
        if (got !== want) begin
            abort_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                $time, field, got, want));
        end
    endtask

    task automatic check_rsp(input int idx, input trans_rsp_t got, input trans_rsp_t want);
        if (got.error !== want.error || got.has_secondary !== want.has_secondary) begin
            abort_run($sformatf("Mismatch at %0t: response %0d flags err=%b sec=%b, expected %b %b",
                                $time, idx, got.error, got.has_secondary,
                                want.error, want.has_secondary));
        end
        check_word($sformatf("response %0d primary", idx), got.primary, want.primary);
        check_word($sformatf("response %0d secondary", idx), got.secondary, want.secondary);
    endtask

    // Channel inputs settle 1 ns after the rising edge, so the falling edge is safe
    always @(negedge clk) begin
        trans_rsp_t want;
        if (!reset && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("Response arrived while no request was outstanding");
            end else begin
                want = exp_q.pop_front();
                check_rsp(rsp_count, rsp, want);
                rsp_count = rsp_count + 1;
            end
        end
    end

    // Output back-pressure in random bursts while stalls are enabled
    // Bursts of up to 63 low cycles let responses pile up behind the output buffer
    always @(posedge clk) begin
        #1;
        if (!stall_enable) begin
            rsp_ready = 1'b1;
        end else if (stall_left > 0) begin
            rsp_ready  = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            rsp_ready  = 1'b1;
            stall_left = $random(seed) & 63;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Holds valid and payload until the transfer edge, then logs the expectation
    task automatic send_req(input trans_req_t r);
        logic taken;
        req_valid = 1'b1;
        req       = r;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        exp_q.push_back(expected_rsp(r));
        sent_count = sent_count + 1;
        req_valid  = 1'b0;
    endtask

    function automatic trans_req_t make_req(input trans_op_e op, input word_t a, input word_t b);
        return '{op: op, operand_a: a, operand_b: b};
    endfunction

    // Random angle in [-HALF_PI, HALF_PI]
    function automatic word_t rand_angle();
        return word_t'($random(seed) % (HALF_PI + 1));
    endfunction

    function automatic trans_req_t rand_req(input int kind);
        word_t x;
        case (kind)
            0: return make_req(OP_SIN, rand_angle(), '0);
            1: return make_req(OP_COS, rand_angle(), '0);
            2: return make_req(OP_SINCOS, rand_angle(), '0);
            3: begin
                // Positive x and signed y, both below 2^20
                x = $random(seed) & 32'h000f_ffff;
                if (x == 0)
                    x = 1;
                return make_req(OP_ATAN, x, word_t'($random(seed) % (1 << 20)));
            end
            4: return make_req(OP_SQRT, word_t'($random(seed) & 32'h7fff_ffff), '0);
            default: return make_req(trans_op_e'(4'd9), rand_angle(), '0);
        endcase
    endfunction

    initial begin
        trans_op_e trig_ops [3];
        word_t     angles [7];
        trig_ops     = '{OP_SIN, OP_COS, OP_SINCOS};
        angles       = '{32'sd0, HALF_PI, -HALF_PI, 32'sd1, -32'sd1,
                         32'sd100, 32'sd32768};
        seed         = 32'h17e7;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        rsp_ready    = 1'b1;
        stall_enable = 1'b0;
        stall_left   = 0;
        sent_count   = 0;
        rsp_count    = 0;
        for (int k = 0; k < CORDIC_ITERS; k++) begin
            atan_tab[k] = word_t'($rtoi($atan(1.0 / (2.0 ** k)) * 65536.0 + 0.5));
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet after reset; the checker flags any stray response
        if (rsp_valid !== 1'b0)
            abort_run("rsp_valid is high right after reset");
        while (req_ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        repeat (3) @(posedge clk);
        #1;

        // Directed angles, then random trig and arctangent
        foreach (trig_ops[i])
            foreach (angles[j])
                send_req(make_req(trig_ops[i], angles[j], '0));
        for (int k = 0; k < N_TRIG_RAND; k++)
            send_req(rand_req(k % 3));
        for (int k = 0; k < N_ATAN_RAND; k++)
            send_req(rand_req(3));

        // Square root corners and random operands
        send_req(make_req(OP_SQRT, 32'sd0, '0));
        send_req(make_req(OP_SQRT, 32'sd65536, '0));
        send_req(make_req(OP_SQRT, 32'sh7fff_ffff, '0));
        for (int k = 0; k < N_SQRT_RAND; k++)
            send_req(rand_req(4));

        // Error cases
        send_req(make_req(trans_op_e'(4'd4), 32'sd1000, '0));
        send_req(make_req(trans_op_e'(4'd6), 32'sd1000, '0));
        send_req(make_req(trans_op_e'(4'd15), 32'sd1000, '0));
        send_req(make_req(OP_SIN, HALF_PI + 1, '0));
        send_req(make_req(OP_COS, -HALF_PI - 1, '0));
        send_req(make_req(OP_SINCOS, HALF_PI + 1, '0));
        send_req(make_req(OP_ATAN, 32'sd0, 32'sd1000));
        send_req(make_req(OP_ATAN, -32'sd5, 32'sd1000));
        send_req(make_req(OP_SQRT, -32'sd1, '0));

        // Mixed stream under random output stalls
        stall_enable = 1'b1;
        for (int k = 0; k < N_MIXED; k++)
            send_req(rand_req(($random(seed) & 32'h7fff_ffff) % 6));
        wait (rsp_count == sent_count);
        stall_enable = 1'b0;

        repeat (5) @(posedge clk);
        if (rsp_count == NUM_TESTS && sent_count == NUM_TESTS && exp_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf("Got %0d responses for %0d requests, %0d planned",
                                rsp_count, sent_count, NUM_TESTS));
        end
    end

endmodule

//--- fpu_trans_top.f
hw/trans_fmt_pkg.sv
hw/trans_op_pkg.sv
hw/trans_skid_buffer.sv
hw/cordic_engine.sv
hw/sqrt_engine.sv
hw/trans_dispatch.sv
hw/fpu_trans_top.sv
tb/tb_fpu_trans.sv
